// ==== include/execUnit_params.svh ====
`ifndef EXEC_UNIT_PARAMS_SVH
`define EXEC_UNIT_PARAMS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////
`define EXEC_DATA_W		32				// Register and memory word
`define EXEC_ISSUE_W	4				// Issue number, also the load tag

//////////////////////////////
// Buffering and constants
//////////////////////////////
`define EXEC_FIFO_DEPTH	4				// Entries per result FIFO

// Single-precision 1.0, written by the preset-one move
`define EXEC_PRESET_ONE	32'h3F80_0000

`endif

// ==== rtl/execTypesPkg.sv ====
`default_nettype none
`include "execUnit_params.svh"

package execTypesPkg;

	typedef logic [`EXEC_DATA_W-1:0]	dataT;
	typedef logic [`EXEC_ISSUE_W-1:0]	issueNoT;
	typedef logic [4:0]					regIdxT;		// 32 architectural registers

	typedef enum logic [3:0] {
		opAdd,
		opSub,
		opAnd,
		opOr,
		opXor,
		opShl,
		opShr,
		opMulLo,
		opMov,
		opMovOne,									// Preset move, writes 1.0
		opMovZero,									// Preset move, writes zero
		opLoad,
		opStore
	} opCodeT;

	typedef struct packed {
		opCodeT		op;
		regIdxT		dst;
		dataT		src1;
		dataT		src2;								// Store data for opStore
	} cmdT;

	typedef struct packed {
		cmdT		cmd;
		issueNoT	issueNo;
	} routedCmdT;

	typedef struct packed {
		issueNoT	issueNo;
		regIdxT		dst;
		dataT		data;
	} resultT;

endpackage

`default_nettype wire

// ==== rtl/memTypesPkg.sv ====
`default_nettype none

package memTypesPkg;

	typedef logic [15:0]	addrT;						// Word address

	// One request per cycle at most
	typedef struct packed {
		logic						wr;					// High for a store
		addrT						addr;
		execTypesPkg::dataT			wrData;
		execTypesPkg::issueNoT		tag;				// Echoed on the load response
	} memReqT;

	typedef struct packed {
		execTypesPkg::issueNoT		tag;
		execTypesPkg::dataT			data;
	} memRspT;

endpackage

`default_nettype wire

// ==== rtl/cmdDecode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "execUnit_params.svh"

module cmdDecode (
	input	wire logic						clock,
	input	wire logic						arstN,
	input	wire logic						cmdValid,
	input	wire execTypesPkg::cmdT			cmd,
	output	logic							aluValid,
	output	logic							lsValid,
	output	logic							movValid,
	output	execTypesPkg::routedCmdT		routed,
	output	execTypesPkg::resultT			movResult
);
	import execTypesPkg::*;

	logic		isAlu;
	logic		isLs;
	logic		isMov;
	logic		writesReg;
	issueNoT	issueCnt;								// Next issue number to hand out
	dataT		movData;

	//////////////////////////////
	// Opcode classification
	//////////////////////////////
	always_comb begin
		isAlu = 1'b0;
		isLs = 1'b0;
		isMov = 1'b0;
		case (cmd.op)
			opAdd, opSub, opAnd, opOr, opXor, opShl, opShr, opMulLo: isAlu = 1'b1;
			opLoad, opStore: isLs = 1'b1;
			opMov, opMovOne, opMovZero: isMov = 1'b1;
			default: ;
		endcase
	end

	assign writesReg = isAlu | isMov | (cmd.op == opLoad);	// Stores take no number

	always_comb begin
		case (cmd.op)
			opMovOne: movData = `EXEC_PRESET_ONE;
			opMovZero: movData = '0;
			default: movData = cmd.src1;				// Plain register move
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			aluValid <= 1'b0;
			lsValid <= 1'b0;
			movValid <= 1'b0;
			issueCnt <= '0;
		end else begin
			aluValid <= cmdValid & isAlu;
			lsValid <= cmdValid & isLs;
			movValid <= cmdValid & isMov;
			if (cmdValid && writesReg) begin
				issueCnt <= issueCnt + issueNoT'(1);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (cmdValid) begin
			routed.cmd <= cmd;
			routed.issueNo <= issueCnt;
			movResult.issueNo <= issueCnt;				// Move result is ready at once
			movResult.dst <= cmd.dst;
			movResult.data <= movData;
		end
	end

	// Every command takes exactly one path
	aOnePath: assert property (@(posedge clock) disable iff (!arstN)
		cmdValid |-> $onehot({isAlu, isLs, isMov}));

endmodule

`default_nettype wire

// ==== rtl/aluStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluStage (
	input	wire logic						clock,
	input	wire logic						arstN,
	input	wire logic						inValid,
	input	wire execTypesPkg::routedCmdT	in,
	output	logic							outValid,
	output	execTypesPkg::resultT			out
);
	import execTypesPkg::*;

	dataT		opA;
	dataT		opB;
	logic [4:0]	shAmt;
	dataT		aluData;
	logic		s1Valid;
	resultT		s1Result;

	assign opA = in.cmd.src1;
	assign opB = in.cmd.src2;
	assign shAmt = opB[4:0];							// Low 5 bits only

	//////////////////////////////
	// Stage 1, compute
	//////////////////////////////
	always_comb begin
		case (in.cmd.op)
			opAdd: aluData = opA + opB;
			opSub: aluData = opA - opB;
			opAnd: aluData = opA & opB;
			opOr: aluData = opA | opB;
			opXor: aluData = opA ^ opB;
			opShl: aluData = opA << shAmt;
			opShr: aluData = opA >> shAmt;				// Logical shift
			opMulLo: aluData = opA * opB;				// Keeps the low word
			default: aluData = '0;
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			s1Valid <= 1'b0;
			outValid <= 1'b0;
		end else begin
			s1Valid <= inValid;
			outValid <= s1Valid;
		end
	end

	always_ff @(posedge clock) begin
		if (inValid) begin
			s1Result.issueNo <= in.issueNo;
			s1Result.dst <= in.cmd.dst;
			s1Result.data <= aluData;
		end
	end

	//////////////////////////////
	// Stage 2, tagged result
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (s1Valid) begin
			out <= s1Result;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/loadStoreStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "execUnit_params.svh"

module loadStoreStage (
	input	wire logic						clock,
	input	wire logic						arstN,
	input	wire logic						inValid,
	input	wire execTypesPkg::routedCmdT	in,
	output	logic							memReqValid,
	output	memTypesPkg::memReqT			memReq,
	input	wire logic						memRspValid,
	input	wire memTypesPkg::memRspT		memRsp,
	output	logic							outValid,
	output	execTypesPkg::resultT			out
);
	import execTypesPkg::*;
	import memTypesPkg::*;

	localparam int TAGS = 1 << `EXEC_ISSUE_W;

	logic				isStore;
	addrT				reqAddr;
	logic [TAGS-1:0]	pending;						// Loads awaiting a response
	regIdxT				dstTable [TAGS];				// Destination per tag

	assign isStore = (in.cmd.op == opStore);

	// Stores address from src1 alone, src2 holds the data
	assign reqAddr = isStore ? addrT'(in.cmd.src1) : addrT'(in.cmd.src1 + in.cmd.src2);

	//////////////////////////////
	// Request side
	//////////////////////////////
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			memReqValid <= 1'b0;
			outValid <= 1'b0;
			pending <= '0;
		end else begin
			memReqValid <= inValid;
			outValid <= memRspValid;
			if (memRspValid) begin
				pending[memRsp.tag] <= 1'b0;
			end
			if (inValid && !isStore) begin
				pending[in.issueNo] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (inValid) begin
			memReq.wr <= isStore;
			memReq.addr <= reqAddr;
			memReq.wrData <= isStore ? in.cmd.src2 : '0;
			memReq.tag <= isStore ? '0 : in.issueNo;
			if (!isStore) begin
				dstTable[in.issueNo] <= in.cmd.dst;
			end
		end
	end

	//////////////////////////////
	// Response side
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (memRspValid) begin
			out.issueNo <= memRsp.tag;					// Tag is the issue number
			out.dst <= dstTable[memRsp.tag];
			out.data <= memRsp.data;
		end
	end

	// Memory must only answer loads it was sent
	aRspPending: assert property (@(posedge clock) disable iff (!arstN)
		memRspValid |-> pending[memRsp.tag]);

endmodule

`default_nettype wire

// ==== rtl/resultFifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "execUnit_params.svh"

module resultFifo #(
	parameter int DEPTH = `EXEC_FIFO_DEPTH
) (
	input	wire logic						clock,
	input	wire logic						arstN,
	input	wire logic						push,
	input	wire execTypesPkg::resultT		din,
	input	wire logic						pop,
	output	logic							headValid,
	output	execTypesPkg::resultT			head
);
	import execTypesPkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	resultT				mem [DEPTH];
	logic [PTR_W-1:0]	wrPtr;
	logic [PTR_W-1:0]	rdPtr;
	logic [CNT_W-1:0]	count;
	logic				full;

	assign full = (count == CNT_W'(DEPTH));
	assign headValid = (count != '0);
	assign head = mem[rdPtr];							// Shown as soon as written

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;								// Both or neither, no change
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wrPtr] <= din;
		end
	end

	// Outstanding limit upstream keeps this from filling
	aNoOverflow: assert property (@(posedge clock) disable iff (!arstN)
		full |-> !push);

endmodule

`default_nettype wire

// ==== rtl/commitSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module commitSelect (
	input	wire logic						clock,
	input	wire logic						arstN,
	input	wire logic						aluHeadValid,
	input	wire execTypesPkg::resultT		aluHead,
	input	wire logic						lsHeadValid,
	input	wire execTypesPkg::resultT		lsHead,
	input	wire logic						movHeadValid,
	input	wire execTypesPkg::resultT		movHead,
	output	logic							aluPop,
	output	logic							lsPop,
	output	logic							movPop,
	output	logic							wbValid,
	output	execTypesPkg::resultT			wb
);
	import execTypesPkg::*;

	issueNoT	nextCommit;								// Oldest issue not yet retired
	logic		aluMatch;
	logic		lsMatch;
	logic		movMatch;
	logic		anyMatch;
	resultT		selHead;

	assign aluMatch = aluHeadValid && (aluHead.issueNo == nextCommit);
	assign lsMatch = lsHeadValid && (lsHead.issueNo == nextCommit);
	assign movMatch = movHeadValid && (movHead.issueNo == nextCommit);
	assign anyMatch = aluMatch | lsMatch | movMatch;

	assign aluPop = aluMatch;
	assign lsPop = lsMatch;
	assign movPop = movMatch;

	always_comb begin
		if (aluMatch) begin
			selHead = aluHead;
		end else if (lsMatch) begin
			selHead = lsHead;
		end else begin
			selHead = movHead;
		end
	end

	//////////////////////////////
	// Write-back register
	//////////////////////////////
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			wbValid <= 1'b0;
			nextCommit <= '0;
		end else begin
			wbValid <= anyMatch;
			if (anyMatch) begin
				nextCommit <= nextCommit + issueNoT'(1);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (anyMatch) begin
			wb <= selHead;
		end
	end

	// Issue numbers are unique across the three paths
	aOneMatch: assert property (@(posedge clock) disable iff (!arstN)
		$onehot0({aluMatch, lsMatch, movMatch}));

endmodule

`default_nettype wire

// ==== rtl/execUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "execUnit_params.svh"

module execUnit (
	input	wire logic						clock,
	input	wire logic						arstN,
	input	wire logic						cmdValid,
	input	wire execTypesPkg::cmdT			cmd,
	output	logic							memReqValid,
	output	memTypesPkg::memReqT			memReq,
	input	wire logic						memRspValid,
	input	wire memTypesPkg::memRspT		memRsp,
	output	logic							wbValid,
	output	execTypesPkg::resultT			wb
);
	import execTypesPkg::*;

	logic		aluValid;
	logic		lsValid;
	logic		movValid;
	routedCmdT	routed;									// Shared by all three paths
	resultT		movResult;

	logic		aluOutValid;
	resultT		aluOut;
	logic		lsOutValid;
	resultT		lsOut;

	logic		aluHeadValid;
	resultT		aluHead;
	logic		lsHeadValid;
	resultT		lsHead;
	logic		movHeadValid;
	resultT		movHead;
	logic		aluPop;
	logic		lsPop;
	logic		movPop;

	//////////////////////////////
	// Decode and execute
	//////////////////////////////
	cmdDecode u_cmdDecode (
		.clock		(clock),
		.arstN		(arstN),
		.cmdValid	(cmdValid),
		.cmd		(cmd),
		.aluValid	(aluValid),
		.lsValid	(lsValid),
		.movValid	(movValid),
		.routed		(routed),
		.movResult	(movResult)
	);

	aluStage u_aluStage (
		.clock		(clock),
		.arstN		(arstN),
		.inValid	(aluValid),
		.in			(routed),
		.outValid	(aluOutValid),
		.out		(aluOut)
	);

	loadStoreStage u_loadStoreStage (
		.clock			(clock),
		.arstN			(arstN),
		.inValid		(lsValid),
		.in				(routed),
		.memReqValid	(memReqValid),
		.memReq			(memReq),
		.memRspValid	(memRspValid),
		.memRsp			(memRsp),
		.outValid		(lsOutValid),
		.out			(lsOut)
	);

	//////////////////////////////
	// Result buffering and commit
	//////////////////////////////
	resultFifo #(.DEPTH(`EXEC_FIFO_DEPTH)) u_aluFifo (
		.clock		(clock),
		.arstN		(arstN),
		.push		(aluOutValid),
		.din		(aluOut),
		.pop		(aluPop),
		.headValid	(aluHeadValid),
		.head		(aluHead)
	);

	resultFifo #(.DEPTH(`EXEC_FIFO_DEPTH)) u_lsFifo (
		.clock		(clock),
		.arstN		(arstN),
		.push		(lsOutValid),
		.din		(lsOut),
		.pop		(lsPop),
		.headValid	(lsHeadValid),
		.head		(lsHead)
	);

	resultFifo #(.DEPTH(`EXEC_FIFO_DEPTH)) u_movFifo (
		.clock		(clock),
		.arstN		(arstN),
		.push		(movValid),							// Move result comes with its strobe
		.din		(movResult),
		.pop		(movPop),
		.headValid	(movHeadValid),
		.head		(movHead)
	);

	commitSelect u_commitSelect (
		.clock			(clock),
		.arstN			(arstN),
		.aluHeadValid	(aluHeadValid),
		.aluHead		(aluHead),
		.lsHeadValid	(lsHeadValid),
		.lsHead			(lsHead),
		.movHeadValid	(movHeadValid),
		.movHead		(movHead),
		.aluPop			(aluPop),
		.lsPop			(lsPop),
		.movPop			(movPop),
		.wbValid		(wbValid),
		.wb				(wb)
	);

endmodule

`default_nettype wire

// ==== verif/tbExecUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "execUnit_params.svh"

module tbExecUnit;
	import execTypesPkg::*;
	import memTypesPkg::*;

	localparam int STIM_RECS = 64;						// Five words per record
	localparam int STIM_WORDS = STIM_RECS * 5;

	logic		clock = 1'b0;
	logic		arstN;
	logic		cmdValid;
	cmdT		cmd;
	logic		memReqValid;
	memReqT		memReq;
	logic		memRspValid;
	memRspT		memRsp;
	logic		wbValid;
	resultT		wb;

	logic [31:0]	stimMem [STIM_WORDS];
	dataT			memModel [addrT];					// Sparse word memory
	cmdT			cmdQ [$];
	resultT			expWbQ [$];
	memReqT			expStoreQ [$];
	issueNoT		pendTag [$];						// Loads awaiting a response
	dataT			pendData [$];
	int				pendDue [$];

	int		cycleCnt = 0;
	int		limitCycles = 0;
	int		issuedCnt = 0;
	int		retiredCnt = 0;
	int		expWbTotal = 0;
	int		recIdx;
	int		base;
	int		pickIdx;
	logic	allDone = 1'b0;
	cmdT	stimCmd;
	resultT	stimWb;
	memReqT	stimStore;

	execUnit u_execUnit (
		.clock			(clock),
		.arstN			(arstN),
		.cmdValid		(cmdValid),
		.cmd			(cmd),
		.memReqValid	(memReqValid),
		.memReq			(memReq),
		.memRspValid	(memRspValid),
		.memRsp			(memRsp),
		.wbValid		(wbValid),
		.wb				(wb)
	);

	always #20 clock = ~clock;							// 40 ns period

	//////////////////////////////
	// Helpers
	//////////////////////////////
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at cycle %0d", cycleCnt);
	endtask

	task automatic checkWb(input resultT got, input resultT exp);
		if (got !== exp) begin
			abortRun($sformatf("ERROR wb issueNo/dst/data got %h/%h/%h expected %h/%h/%h",
				got.issueNo, got.dst, got.data, exp.issueNo, exp.dst, exp.data));
		end
	endtask

	task automatic checkMemReq(input memReqT got, input memReqT exp);
		if (got !== exp) begin
			abortRun($sformatf("ERROR memReq wr/addr/wrData/tag got %h/%h/%h/%h expected %h/%h/%h/%h",
				got.wr, got.addr, got.wrData, got.tag, exp.wr, exp.addr, exp.wrData, exp.tag));
		end
	endtask

	// Unloaded words read back a pattern built from the address
	function automatic dataT readWord(input addrT a);
		if (memModel.exists(a)) begin
			return memModel[a];
		end
		return {a, ~a};
	endfunction

	task automatic sendCmd(input cmdT c);
		logic writesReg;
		writesReg = (c.op != opStore);
		@(posedge clock);								// Retire count is stable here
		while (writesReg && (issuedCnt - retiredCnt) >= `EXEC_FIFO_DEPTH) @(posedge clock);
		@(negedge clock);
		cmdValid = 1'b1;
		cmd = c;
		if (writesReg) begin
			issuedCnt++;
		end
		@(negedge clock);
		cmdValid = 1'b0;
	endtask

	//////////////////////////////
	// Monitor and memory model
	//////////////////////////////
	always @(negedge clock) begin
		cycleCnt++;
		if (arstN) begin
			if (wbValid) begin
				if (expWbQ.size() == 0) begin
					abortRun("a write-back appeared after all expected write-backs");
				end else begin
					checkWb(wb, expWbQ.pop_front());
					retiredCnt++;
				end
			end
			if (memReqValid && memReq.wr) begin
				if (expStoreQ.size() == 0) begin
					abortRun("a store request appeared that was not expected");
				end else begin
					checkMemReq(memReq, expStoreQ.pop_front());
					memModel[memReq.addr] = memReq.wrData;
				end
			end else if (memReqValid) begin
				pendTag.push_back(memReq.tag);
				pendData.push_back(readWord(memReq.addr));
				pendDue.push_back(cycleCnt + int'($urandom_range(6, 1)));
			end
			// Oldest ready load goes first, so short delays overtake
			memRspValid = 1'b0;
			pickIdx = -1;
			for (int i = 0; i < pendTag.size() && pickIdx < 0; i++) begin
				if (pendDue[i] <= cycleCnt) begin
					pickIdx = i;
				end
			end
			if (pickIdx >= 0) begin
				memRspValid = 1'b1;
				memRsp.tag = pendTag[pickIdx];
				memRsp.data = pendData[pickIdx];
				pendTag.delete(pickIdx);
				pendData.delete(pickIdx);
				pendDue.delete(pickIdx);
			end
		end
		if (!allDone && cycleCnt >= limitCycles) begin
			abortRun($sformatf("timeout after %0d cycles with %0d of %0d write-backs seen",
				cycleCnt, retiredCnt, expWbTotal));
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial begin
		arstN = 1'b0;
		cmdValid = 1'b0;
		cmd = '0;
		memRspValid = 1'b0;
		memRsp = '0;
		void'($urandom(32'h50871a2b));
		for (int i = 0; i < STIM_WORDS; i++) begin
			stimMem[i] = '0;							// Kind zero ends the records
		end
		$readmemh("verif/execUnit_stim.txt", stimMem);
		recIdx = 0;
		while (recIdx < STIM_RECS && stimMem[recIdx * 5] != 0) begin
			base = recIdx * 5;
			case (stimMem[base])
				1: memModel[addrT'(stimMem[base + 1])] = stimMem[base + 2];
				2: begin
					stimCmd.op = opCodeT'(stimMem[base + 1][3:0]);
					stimCmd.dst = regIdxT'(stimMem[base + 2]);
					stimCmd.src1 = stimMem[base + 3];
					stimCmd.src2 = stimMem[base + 4];
					cmdQ.push_back(stimCmd);
				end
				3: begin
					stimWb.issueNo = issueNoT'(expWbQ.size());	// Numbers follow issue order
					stimWb.dst = regIdxT'(stimMem[base + 1]);
					stimWb.data = stimMem[base + 2];
					expWbQ.push_back(stimWb);
				end
				4: begin
					stimStore.wr = 1'b1;
					stimStore.addr = addrT'(stimMem[base + 1]);
					stimStore.wrData = stimMem[base + 2];
					stimStore.tag = '0;
					expStoreQ.push_back(stimStore);
				end
				default: abortRun("the stimulus file holds an unknown record kind");
			endcase
			recIdx++;
		end
		if (cmdQ.size() == 0) begin
			abortRun("the stimulus file holds no commands");
		end
		expWbTotal = expWbQ.size();
		limitCycles = 40 * cmdQ.size() + 200;

		repeat (8) @(negedge clock);
		arstN = 1'b1;

		foreach (cmdQ[i]) begin
			sendCmd(cmdQ[i]);
		end
		while (retiredCnt < expWbTotal || expStoreQ.size() != 0 || pendTag.size() != 0) begin
			@(posedge clock);
		end
		allDone = 1'b1;
		// Watch for stray write-backs up to the limit
		while (cycleCnt < limitCycles) @(posedge clock);

		if (retiredCnt == expWbTotal && expWbQ.size() == 0 && expStoreQ.size() == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			abortRun("the run ended with expected write-backs or stores missing");
		end
	end

endmodule

`default_nettype wire

// ==== verif/execUnit_stim.txt ====
// Columns: kind f1 f2 f3 f4, hex. 1 preload addr data, 2 command op dst src1 src2,
// 3 write-back dst data in issue order, 4 store addr data. Op 0..c is add..store
1 0010 11111111 0 0
1 0012 33333333 0 0
1 0020 cafef00d 0 0
1 0021 0badc0de 0 0
2 0 01 00000005 00000003
2 1 02 00000003 00000005
2 2 03 f0f0f0f0 ff00ff00
2 3 04 f0f0f0f0 0f0f0000
2 4 05 aaaa5555 ffff0000
2 5 06 00000001 0000003f
2 6 07 80000000 00000024
2 7 08 00010001 00010001
2 7 09 ffffffff ffffffff
2 b 0a 00000010 00000002
2 b 0b 0000000f 00000001
2 8 0c 12345678 00000000
2 b 0d 00010020 00000000
2 9 0e 00000000 00000000
2 c 00 00000030 deadbeef
2 b 0f 00000020 00000001
2 a 10 ffffffff 00000000
2 b 11 00000030 00000000
3 01 00000008 0 0
3 02 fffffffe 0 0
3 03 f000f000 0 0
3 04 fffff0f0 0 0
3 05 55555555 0 0
3 06 80000000 0 0
3 07 08000000 0 0
3 08 00020001 0 0
3 09 00000001 0 0
3 0a 33333333 0 0
3 0b 11111111 0 0
3 0c 12345678 0 0
3 0d cafef00d 0 0
3 0e 3f800000 0 0
3 0f 0badc0de 0 0
3 10 00000000 0 0
3 11 deadbeef 0 0
4 0030 deadbeef 0 0

// ==== build.f ====
+incdir+include
rtl/execTypesPkg.sv
rtl/memTypesPkg.sv
rtl/cmdDecode.sv
rtl/aluStage.sv
rtl/loadStoreStage.sv
rtl/resultFifo.sv
rtl/commitSelect.sv
rtl/execUnit.sv
verif/tbExecUnit.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the execUnit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tbExecUnit -o simExecUnit
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/simExecUnit
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi
exit 0
